// ==== src/wb_pkg.sv ====
package wb_pkg;

    // datapath widths
    localparam int xlen      = 32;
    localparam int csr_num_w = 14;
    localparam int rf_addr_w = 5;
    localparam int ecode_w   = 6;

    // csr addresses
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h0;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h1;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h4;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h5;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h6;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h7;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h30;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h31;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h32;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h33;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h41;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h42;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h44;

    // exception codes
    localparam logic [ecode_w-1:0] ecode_int = 6'h0;
    localparam logic [ecode_w-1:0] ecode_ade = 6'h8;
    localparam logic [ecode_w-1:0] ecode_ale = 6'h9;
    localparam logic [ecode_w-1:0] ecode_sys = 6'hb;
    localparam logic [ecode_w-1:0] ecode_brk = 6'hc;
    localparam logic [ecode_w-1:0] ecode_ine = 6'hd;

    // exception flag vector, one bit per cause
    localparam int excp_w    = 5;
    localparam int excp_adef = 0;
    localparam int excp_ine  = 1;
    localparam int excp_sys  = 2;
    localparam int excp_brk  = 3;
    localparam int excp_ale  = 4;

    // crmd fields, prmd uses the same layout
    localparam int crmd_plv = 0;
    localparam int crmd_ie  = 2;

    // timer line in estat.is
    localparam int estat_is_timer = 11;

    // tcfg fields
    localparam int tcfg_en       = 0;
    localparam int tcfg_periodic = 1;
    localparam int tcfg_initval  = 2;

endpackage

// ==== src/mem_wb_if.sv ====
`timescale 1ns/1ps

interface mem_wb_if import wb_pkg::*; ();

    logic                 valid;
    logic                 allowin;
    logic                 rf_we;
    logic [rf_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]      rf_result;
    logic [xlen-1:0]      pc;
    logic                 res_from_csr;
    logic [csr_num_w-1:0] csr_num;
    logic                 csr_we;
    logic [xlen-1:0]      csr_wmask;
    logic [xlen-1:0]      csr_wvalue;
    logic                 ertn;
    logic [excp_w-1:0]    excp;
    logic [xlen-1:0]      vaddr;

    modport src (
        output valid, rf_we, rf_waddr, rf_result, pc, res_from_csr, csr_num, csr_we,
               csr_wmask, csr_wvalue, ertn, excp, vaddr,
        input  allowin
    );

    modport dst (
        input  valid, rf_we, rf_waddr, rf_result, pc, res_from_csr, csr_num, csr_we,
               csr_wmask, csr_wvalue, ertn, excp, vaddr,
        output allowin
    );

endinterface

// ==== src/wb_csr_if.sv ====
`timescale 1ns/1ps

interface wb_csr_if import wb_pkg::*; ();

    // stage to csr
    logic [csr_num_w-1:0] csr_num;
    logic                 csr_we;
    logic [xlen-1:0]      csr_wmask;
    logic [xlen-1:0]      csr_wvalue;
    logic                 ertn;
    logic                 ex;
    logic [ecode_w-1:0]   ecode;
    logic [xlen-1:0]      pc;
    logic                 badv_we;
    logic [xlen-1:0]      badv;

    // csr back to stage
    logic [xlen-1:0]      csr_rvalue;
    logic [xlen-1:0]      redirect_pc;
    logic                 has_int;

    modport stage (
        output csr_num, csr_we, csr_wmask, csr_wvalue, ertn, ex, ecode, pc, badv_we, badv,
        input  csr_rvalue, redirect_pc, has_int
    );

    modport csr (
        input  csr_num, csr_we, csr_wmask, csr_wvalue, ertn, ex, ecode, pc, badv_we, badv,
        output csr_rvalue, redirect_pc, has_int
    );

endinterface

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import wb_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic [7:0] hw_int,
    input  logic       ipi_int,
    wb_csr_if.csr      csr
);

    logic [1:0]         cur_plv;
    logic               cur_ie;
    logic [1:0]         prmd_pplv;
    logic               prmd_pie;
    logic [12:0]        ecfg_lie;
    logic [12:0]        estat_is;
    logic [ecode_w-1:0] estat_ecode;
    logic [xlen-1:0]    era;
    logic [xlen-1:0]    badv;
    logic [xlen-1:0]    eentry;
    logic [xlen-1:0]    save0;
    logic [xlen-1:0]    save1;
    logic [xlen-1:0]    save2;
    logic [xlen-1:0]    save3;
    logic [xlen-1:0]    tcfg;
    logic [xlen-1:0]    tval;

    logic [xlen-1:0]    rvalue;
    logic [xlen-1:0]    merged;
    logic               wr_crmd;
    logic               wr_prmd;
    logic               wr_ecfg;
    logic               wr_estat;
    logic               wr_tcfg;
    logic               ticlr_clr;
    logic               timer_fire;

    // read mux, also the base for masked writes
    always_comb begin
        case (csr.csr_num)
            csr_crmd:   rvalue = {29'b0, cur_ie, cur_plv};
            csr_prmd:   rvalue = {29'b0, prmd_pie, prmd_pplv};
            csr_ecfg:   rvalue = {19'b0, ecfg_lie};
            csr_estat:  rvalue = {10'b0, estat_ecode, 3'b0, estat_is};
            csr_era:    rvalue = era;
            csr_badv:   rvalue = badv;
            csr_eentry: rvalue = eentry;
            csr_save0:  rvalue = save0;
            csr_save1:  rvalue = save1;
            csr_save2:  rvalue = save2;
            csr_save3:  rvalue = save3;
            csr_tcfg:   rvalue = tcfg;
            csr_tval:   rvalue = tval;
            default:    rvalue = '0;
        endcase
    end

    assign csr.csr_rvalue = rvalue;
    assign merged = (rvalue & ~csr.csr_wmask) | (csr.csr_wvalue & csr.csr_wmask);

    assign wr_crmd  = csr.csr_we && (csr.csr_num == csr_crmd);
    assign wr_prmd  = csr.csr_we && (csr.csr_num == csr_prmd);
    assign wr_ecfg  = csr.csr_we && (csr.csr_num == csr_ecfg);
    assign wr_estat = csr.csr_we && (csr.csr_num == csr_estat);
    assign wr_tcfg  = csr.csr_we && (csr.csr_num == csr_tcfg);
    // ticlr reads as zero, so the merge leaves just the written bit
    assign ticlr_clr = csr.csr_we && (csr.csr_num == csr_ticlr) && merged[0];

    assign timer_fire = tcfg[tcfg_en] && !wr_tcfg && (tval == 32'd1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cur_plv   <= 2'd0;
            cur_ie    <= 1'b0;
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (csr.ex) begin
            prmd_pplv <= cur_plv;
            prmd_pie  <= cur_ie;
            cur_plv   <= 2'd0;
            cur_ie    <= 1'b0;
        end else if (csr.ertn) begin
            cur_plv <= prmd_pplv;
            cur_ie  <= prmd_pie;
        end else begin
            if (wr_crmd) begin
                cur_plv <= merged[crmd_plv +: 2];
                cur_ie  <= merged[crmd_ie];
            end
            if (wr_prmd) begin
                prmd_pplv <= merged[crmd_plv +: 2];
                prmd_pie  <= merged[crmd_ie];
            end
        end
    end

    // lie bit 10 is reserved
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
        end else if (wr_ecfg) begin
            ecfg_lie <= {merged[12:11], 1'b0, merged[9:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is    <= '0;
            estat_ecode <= '0;
        end else begin
            estat_is[9:2] <= hw_int;
            estat_is[12]  <= ipi_int;
            // only the two software lines are writable
            if (wr_estat) begin
                estat_is[1:0] <= merged[1:0];
            end
            if (timer_fire) begin
                estat_is[estat_is_timer] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[estat_is_timer] <= 1'b0;
            end
            if (csr.ex) begin
                estat_ecode <= csr.ecode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
            save0  <= '0;
            save1  <= '0;
            save2  <= '0;
            save3  <= '0;
        end else begin
            if (csr.ex) begin
                era <= csr.pc;
            end else if (csr.csr_we && csr.csr_num == csr_era) begin
                era <= merged;
            end
            if (csr.badv_we) begin
                badv <= csr.badv;
            end else if (csr.csr_we && csr.csr_num == csr_badv) begin
                badv <= merged;
            end
            // entry is 64-byte aligned
            if (csr.csr_we && csr.csr_num == csr_eentry) begin
                eentry <= {merged[xlen-1:6], 6'b0};
            end
            if (csr.csr_we && csr.csr_num == csr_save0) save0 <= merged;
            if (csr.csr_we && csr.csr_num == csr_save1) save1 <= merged;
            if (csr.csr_we && csr.csr_num == csr_save2) save2 <= merged;
            if (csr.csr_we && csr.csr_num == csr_save3) save3 <= merged;
        end
    end

    // count-down timer, stops at zero unless periodic
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg <= '0;
            tval <= '0;
        end else if (wr_tcfg) begin
            tcfg <= merged;
            tval <= {merged[xlen-1:tcfg_initval], {tcfg_initval{1'b0}}};
        end else if (tcfg[tcfg_en]) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else if (tcfg[tcfg_periodic]) begin
                tval <= {tcfg[xlen-1:tcfg_initval], {tcfg_initval{1'b0}}};
            end
        end
    end

    assign csr.has_int     = cur_ie && (|(estat_is & ecfg_lie));
    assign csr.redirect_pc = csr.ex ? eentry : era;

endmodule

// ==== src/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    mem_wb_if.dst                mem,
    wb_csr_if.stage              csr,
    output logic                 rf_we,
    output logic [rf_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]      rf_wdata,
    output logic [xlen-1:0]      debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [rf_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]      debug_wb_rf_wdata,
    output logic                 wb_flush
);

    logic                 wb_valid;
    logic                 ready_go;
    logic                 allowin;
    logic                 wb_rf_we;
    logic [rf_addr_w-1:0] wb_rf_waddr;
    logic [xlen-1:0]      wb_rf_result;
    logic [xlen-1:0]      wb_pc;
    logic                 wb_res_from_csr;
    logic [csr_num_w-1:0] wb_csr_num;
    logic                 wb_csr_we;
    logic [xlen-1:0]      wb_csr_wmask;
    logic [xlen-1:0]      wb_csr_wvalue;
    logic                 wb_ertn;
    logic [excp_w-1:0]    wb_excp;
    logic [xlen-1:0]      wb_vaddr;
    logic                 cause;
    logic [ecode_w-1:0]   ecode;

    assign ready_go    = 1'b1;
    assign allowin     = !wb_valid || ready_go;
    assign mem.allowin = allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (allowin) begin
            wb_valid <= mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.valid && allowin) begin
            wb_rf_we        <= mem.rf_we;
            wb_rf_waddr     <= mem.rf_waddr;
            wb_rf_result    <= mem.rf_result;
            wb_pc           <= mem.pc;
            wb_res_from_csr <= mem.res_from_csr;
            wb_csr_num      <= mem.csr_num;
            wb_csr_we       <= mem.csr_we;
            wb_csr_wmask    <= mem.csr_wmask;
            wb_csr_wvalue   <= mem.csr_wvalue;
            wb_ertn         <= mem.ertn;
            wb_excp         <= mem.excp;
            wb_vaddr        <= mem.vaddr;
        end
    end

    // pending interrupt is taken on the retiring instruction
    assign cause = csr.has_int || (|wb_excp);

    // fixed priority, interrupt first
    always_comb begin
        if (csr.has_int)                ecode = ecode_int;
        else if (wb_excp[excp_adef])    ecode = ecode_ade;
        else if (wb_excp[excp_ine])     ecode = ecode_ine;
        else if (wb_excp[excp_sys])     ecode = ecode_sys;
        else if (wb_excp[excp_brk])     ecode = ecode_brk;
        else if (wb_excp[excp_ale])     ecode = ecode_ale;
        else                            ecode = ecode_int;
    end

    assign csr.csr_num    = wb_csr_num;
    assign csr.csr_we     = wb_valid && wb_csr_we && !cause;
    assign csr.csr_wmask  = wb_csr_wmask;
    assign csr.csr_wvalue = wb_csr_wvalue;
    assign csr.ertn       = wb_valid && wb_ertn;
    assign csr.ex         = wb_valid && cause;
    assign csr.ecode      = ecode;
    assign csr.pc         = wb_pc;
    assign csr.badv_we    = csr.ex && (ecode == ecode_ade || ecode == ecode_ale);
    assign csr.badv       = (ecode == ecode_ade) ? wb_pc : wb_vaddr;

    assign rf_we    = wb_valid && wb_rf_we && !cause;
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = wb_res_from_csr ? csr.csr_rvalue : wb_rf_result;

    assign wb_flush = csr.ex || csr.ertn;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 we,
    input  logic [rf_addr_w-1:0] waddr,
    input  logic [xlen-1:0]      wdata,
    input  logic [rf_addr_w-1:0] raddr,
    output logic [xlen-1:0]      rdata
);

    logic [xlen-1:0] regs [2**rf_addr_w];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// ==== src/wb_top.sv ====
`timescale 1ns/1ps

module wb_top import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 mem_valid,
    input  logic                 mem_rf_we,
    input  logic [rf_addr_w-1:0] mem_rf_waddr,
    input  logic [xlen-1:0]      mem_rf_result,
    input  logic [xlen-1:0]      mem_pc,
    input  logic                 mem_res_from_csr,
    input  logic [csr_num_w-1:0] mem_csr_num,
    input  logic                 mem_csr_we,
    input  logic [xlen-1:0]      mem_csr_wmask,
    input  logic [xlen-1:0]      mem_csr_wvalue,
    input  logic                 mem_ertn,
    input  logic [excp_w-1:0]    mem_excp,
    input  logic [xlen-1:0]      mem_vaddr,
    input  logic [7:0]           hw_int,
    input  logic                 ipi_int,
    input  logic [rf_addr_w-1:0] rf_raddr,
    output logic                 wb_allowin,
    output logic [xlen-1:0]      rf_rdata,
    output logic [xlen-1:0]      debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [rf_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]      debug_wb_rf_wdata,
    output logic                 wb_flush,
    output logic [xlen-1:0]      redirect_pc,
    output logic                 has_int
);

    logic                 rf_we;
    logic [rf_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]      rf_wdata;

    mem_wb_if mem_if ();
    wb_csr_if csr_if ();

    // memory-side fields onto the bus
    assign mem_if.valid        = mem_valid;
    assign mem_if.rf_we        = mem_rf_we;
    assign mem_if.rf_waddr     = mem_rf_waddr;
    assign mem_if.rf_result    = mem_rf_result;
    assign mem_if.pc           = mem_pc;
    assign mem_if.res_from_csr = mem_res_from_csr;
    assign mem_if.csr_num      = mem_csr_num;
    assign mem_if.csr_we       = mem_csr_we;
    assign mem_if.csr_wmask    = mem_csr_wmask;
    assign mem_if.csr_wvalue   = mem_csr_wvalue;
    assign mem_if.ertn         = mem_ertn;
    assign mem_if.excp         = mem_excp;
    assign mem_if.vaddr        = mem_vaddr;
    assign wb_allowin          = mem_if.allowin;

    assign redirect_pc = csr_if.redirect_pc;
    assign has_int     = csr_if.has_int;

    wb_stage i_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem               (mem_if.dst),
        .csr               (csr_if.stage),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .wb_flush          (wb_flush)
    );

    csr_file i_csr_file (
        .clk     (clk),
        .resetn  (resetn),
        .hw_int  (hw_int),
        .ipi_int (ipi_int),
        .csr     (csr_if.csr)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

// ==== tb/wb_model.svh ====
`ifndef wb_model_svh
`define wb_model_svh

// architectural state
logic [1:0]           m_plv;
logic                 m_ie;
logic [1:0]           m_pplv;
logic                 m_pie;
logic [12:0]          m_lie;
logic [12:0]          m_is;
logic [ecode_w-1:0]   m_ecode;
logic [xlen-1:0]      m_era;
logic [xlen-1:0]      m_badv;
logic [xlen-1:0]      m_eentry;
logic [xlen-1:0]      m_save [4];
logic [xlen-1:0]      m_tcfg;
logic [xlen-1:0]      m_tval;
logic [xlen-1:0]      m_regs [32];
bit                   m_written [32];

// instruction held in write-back
logic                 w_valid;
logic                 w_rf_we;
logic [rf_addr_w-1:0] w_waddr;
logic [xlen-1:0]      w_result;
logic [xlen-1:0]      w_pc;
logic                 w_from_csr;
logic [csr_num_w-1:0] w_csr_num;
logic                 w_csr_we;
logic [xlen-1:0]      w_wmask;
logic [xlen-1:0]      w_wvalue;
logic                 w_ertn;
logic [excp_w-1:0]    w_excp;
logic [xlen-1:0]      w_vaddr;

function automatic logic [xlen-1:0] csr_value(input logic [csr_num_w-1:0] num);
    case (num)
        csr_crmd:   return {29'b0, m_ie, m_plv};
        csr_prmd:   return {29'b0, m_pie, m_pplv};
        csr_ecfg:   return {19'b0, m_lie};
        csr_estat:  return {10'b0, m_ecode, 3'b0, m_is};
        csr_era:    return m_era;
        csr_badv:   return m_badv;
        csr_eentry: return m_eentry;
        csr_save0:  return m_save[0];
        csr_save1:  return m_save[1];
        csr_save2:  return m_save[2];
        csr_save3:  return m_save[3];
        csr_tcfg:   return m_tcfg;
        csr_tval:   return m_tval;
        default:    return '0;
    endcase
endfunction

function automatic logic int_pending();
    return m_ie && ((m_is & m_lie) != 13'd0);
endfunction

// interrupt, ade, ine, sys, brk, ale
function automatic logic [ecode_w-1:0] cause_code(input logic hint);
    if (hint) return ecode_int;
    if (w_excp[excp_adef]) return ecode_ade;
    if (w_excp[excp_ine]) return ecode_ine;
    if (w_excp[excp_sys]) return ecode_sys;
    if (w_excp[excp_brk]) return ecode_brk;
    if (w_excp[excp_ale]) return ecode_ale;
    return ecode_int;
endfunction

task automatic model_reset();
    m_plv    = '0;
    m_ie     = 1'b0;
    m_pplv   = '0;
    m_pie    = 1'b0;
    m_lie    = '0;
    m_is     = '0;
    m_ecode  = '0;
    m_era    = '0;
    m_badv   = '0;
    m_eentry = '0;
    m_tcfg   = '0;
    m_tval   = '0;
    w_valid  = 1'b0;
    w_waddr  = '0;
    for (int i = 0; i < 4; i++) begin
        m_save[i] = '0;
    end
    for (int i = 0; i < 32; i++) begin
        m_written[i] = 1'b0;
    end
endtask

// one rising edge: retire the held instruction, then take the next one
task automatic model_step(input bit accepted);
    logic               hint;
    logic               ex;
    logic               cwe;
    logic               fire;
    logic               clr;
    logic [ecode_w-1:0] code;
    logic [xlen-1:0]    merged;
    logic [xlen-1:0]    wdata;
    hint   = int_pending();
    ex     = w_valid && (hint || w_excp != '0);
    cwe    = w_valid && w_csr_we && !ex;
    code   = cause_code(hint);
    merged = (csr_value(w_csr_num) & ~w_wmask) | (w_wvalue & w_wmask);
    wdata  = w_from_csr ? csr_value(w_csr_num) : w_result;
    fire   = m_tcfg[tcfg_en] && !(cwe && w_csr_num == csr_tcfg) && m_tval == 32'd1;
    clr    = cwe && w_csr_num == csr_ticlr && merged[0];

    if (w_valid && w_rf_we && !ex && w_waddr != 5'd0) begin
        m_regs[w_waddr]    = wdata;
        m_written[w_waddr] = 1'b1;
    end
    if (ex) begin
        m_pplv = m_plv;
        m_pie  = m_ie;
        m_plv  = 2'd0;
        m_ie   = 1'b0;
    end else if (w_valid && w_ertn) begin
        m_plv = m_pplv;
        m_ie  = m_pie;
    end else if (cwe && w_csr_num == csr_crmd) begin
        {m_ie, m_plv} = merged[2:0];
    end else if (cwe && w_csr_num == csr_prmd) begin
        {m_pie, m_pplv} = merged[2:0];
    end
    // lie bit 10 does not exist
    if (cwe && w_csr_num == csr_ecfg) begin
        m_lie = {merged[12:11], 1'b0, merged[9:0]};
    end
    m_is[9:2] = hw_int;
    m_is[12]  = ipi_int;
    if (cwe && w_csr_num == csr_estat) begin
        m_is[1:0] = merged[1:0];
    end
    if (fire) begin
        m_is[estat_is_timer] = 1'b1;
    end else if (clr) begin
        m_is[estat_is_timer] = 1'b0;
    end
    if (ex) begin
        m_ecode = code;
        m_era   = w_pc;
    end else if (cwe && w_csr_num == csr_era) begin
        m_era = merged;
    end
    if (ex && (code == ecode_ade || code == ecode_ale)) begin
        m_badv = (code == ecode_ade) ? w_pc : w_vaddr;
    end else if (cwe && w_csr_num == csr_badv) begin
        m_badv = merged;
    end
    if (cwe && w_csr_num == csr_eentry) begin
        m_eentry = {merged[31:6], 6'b0};
    end
    if (cwe && w_csr_num >= csr_save0 && w_csr_num <= csr_save3) begin
        m_save[w_csr_num[1:0]] = merged;
    end
    if (cwe && w_csr_num == csr_tcfg) begin
        m_tcfg = merged;
        m_tval = {merged[31:2], 2'b0};
    end else if (m_tcfg[tcfg_en]) begin
        if (m_tval != 32'd0) begin
            m_tval = m_tval - 32'd1;
        end else if (m_tcfg[tcfg_periodic]) begin
            m_tval = {m_tcfg[31:2], 2'b0};
        end
    end

    w_valid = accepted;
    if (accepted) begin
        w_rf_we    = mem_rf_we;
        w_waddr    = mem_rf_waddr;
        w_result   = mem_rf_result;
        w_pc       = mem_pc;
        w_from_csr = mem_res_from_csr;
        w_csr_num  = mem_csr_num;
        w_csr_we   = mem_csr_we;
        w_wmask    = mem_csr_wmask;
        w_wvalue   = mem_csr_wvalue;
        w_ertn     = mem_ertn;
        w_excp     = mem_excp;
        w_vaddr    = mem_vaddr;
    end
endtask

`endif

// ==== tb/wb_tb.sv ====
`timescale 1ns/1ps

module wb_tb import wb_pkg::*; ();

    localparam int n_instr    = 1500;
    // bubbles stay near one in eight, so twice the count leaves headroom
    localparam int max_cycles = 2 * n_instr + 1000;

    logic                 clk;
    logic                 resetn;
    logic                 mem_valid;
    logic                 mem_rf_we;
    logic [rf_addr_w-1:0] mem_rf_waddr;
    logic [xlen-1:0]      mem_rf_result;
    logic [xlen-1:0]      mem_pc;
    logic                 mem_res_from_csr;
    logic [csr_num_w-1:0] mem_csr_num;
    logic                 mem_csr_we;
    logic [xlen-1:0]      mem_csr_wmask;
    logic [xlen-1:0]      mem_csr_wvalue;
    logic                 mem_ertn;
    logic [excp_w-1:0]    mem_excp;
    logic [xlen-1:0]      mem_vaddr;
    logic [7:0]           hw_int;
    logic                 ipi_int;
    logic [rf_addr_w-1:0] rf_raddr;
    logic                 wb_allowin;
    logic [xlen-1:0]      rf_rdata;
    logic [xlen-1:0]      debug_wb_pc;
    logic [3:0]           debug_wb_rf_we;
    logic [rf_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]      debug_wb_rf_wdata;
    logic                 wb_flush;
    logic [xlen-1:0]      redirect_pc;
    logic                 has_int;

    logic [31:0]          seed = 32'd23;
    bit                   allowin_seen;
    int                   issued;
    int                   cycle_count;

    `include "wb_model.svh"

    wb_top i_wb_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [csr_num_w-1:0] pick_csr(input logic [3:0] p);
        case (p)
            4'd0:    return csr_save0;
            4'd1:    return csr_save1;
            4'd2:    return csr_save2;
            4'd3:    return csr_save3;
            4'd4:    return csr_ecfg;
            4'd5:    return csr_eentry;
            4'd6:    return csr_crmd;
            4'd7:    return csr_tcfg;
            4'd8:    return csr_ticlr;
            4'd9:    return csr_estat;
            4'd10:   return csr_prmd;
            4'd11:   return csr_era;
            4'd12:   return csr_badv;
            4'd13:   return csr_tval;
            4'd14:   return csr_crmd;
            default: return csr_ecfg;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one random instruction on the memory side
    task automatic drive_instr(input bit first);
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        r  = lcg_next();
        r2 = lcg_next();
        r3 = lcg_next();
        mem_valid        = first || (r[31:29] != 3'd0);
        mem_rf_we        = 1'b1;
        mem_rf_waddr     = r[19:15];
        mem_rf_result    = lcg_next();
        mem_pc           = {r2[31:2], 2'b0};
        mem_res_from_csr = 1'b0;
        mem_csr_we       = 1'b0;
        mem_csr_num      = pick_csr(r[23:20]);
        mem_csr_wmask    = lcg_next();
        mem_csr_wvalue   = lcg_next();
        mem_ertn         = 1'b0;
        mem_excp         = '0;
        mem_vaddr        = lcg_next();
        case (r[27:24])
            4'd6, 4'd7: mem_res_from_csr = 1'b1;
            4'd8, 4'd9, 4'd10, 4'd11: begin
                mem_res_from_csr = 1'b1;
                mem_csr_we       = 1'b1;
            end
            4'd12: begin
                mem_excp         = (r[4:0] == 5'd0) ? 5'b10000 : r[4:0];
                mem_csr_we       = r[5];
                mem_res_from_csr = r[6];
            end
            4'd13: begin
                mem_ertn  = 1'b1;
                mem_rf_we = r[7];
            end
            default: ;
        endcase
        // short timer periods so it expires within the run
        if (mem_csr_num == csr_tcfg) begin
            mem_csr_wvalue = {24'b0, r3[5:0], r3[7:6]};
        end
        if (first) begin
            mem_rf_we        = 1'b1;
            mem_rf_waddr     = 5'd1;
            mem_res_from_csr = 1'b1;
            mem_csr_we       = 1'b0;
            mem_csr_num      = csr_crmd;
            mem_excp         = '0;
            mem_ertn         = 1'b0;
        end
        if (r3[31:27] == 5'd0) begin
            hw_int = r3[15:8];
        end else if (r3[31:29] == 3'd7) begin
            hw_int = '0;
        end
        ipi_int = (r3[20:16] == 5'd0);
    endtask

    task automatic check_outputs();
        logic exp_ex;
        logic exp_we;
        exp_ex = w_valid && (int_pending() || w_excp != '0);
        exp_we = w_valid && w_rf_we && !exp_ex;
        allowin_seen = wb_allowin;
        check("wb_allowin", 32'(wb_allowin), 32'd1);
        check("has_int", 32'(has_int), 32'(int_pending()));
        check("wb_flush", 32'(wb_flush), 32'(exp_ex || (w_valid && w_ertn)));
        check("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'({4{exp_we}}));
        if (w_valid) begin
            check("debug_wb_pc", debug_wb_pc, w_pc);
        end
        if (exp_we) begin
            check("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(w_waddr));
            check("debug_wb_rf_wdata", debug_wb_rf_wdata,
                  w_from_csr ? csr_value(w_csr_num) : w_result);
        end
        if (exp_ex) begin
            check("redirect_pc", redirect_pc, m_eentry);
        end else if (w_valid && w_ertn) begin
            check("redirect_pc", redirect_pc, m_era);
        end
        if (rf_raddr == 5'd0 || m_written[rf_raddr]) begin
            check("rf_rdata", rf_rdata, (rf_raddr == 5'd0) ? 32'd0 : m_regs[rf_raddr]);
        end
    endtask

    task automatic run_cycle(input bit idle);
        bit                   accepted;
        logic [rf_addr_w-1:0] retired_waddr;
        @(posedge clk);
        accepted = mem_valid && allowin_seen;
        // destination of the instruction that commits at this edge
        retired_waddr = w_waddr;
        model_step(accepted);
        if (accepted) begin
            issued++;
        end
        #2;
        rf_raddr = retired_waddr;
        if (idle) begin
            mem_valid = 1'b0;
        end else begin
            drive_instr(1'b0);
        end
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        resetn           = 1'b0;
        mem_valid        = 1'b0;
        mem_rf_we        = 1'b0;
        mem_rf_waddr     = '0;
        mem_rf_result    = '0;
        mem_pc           = '0;
        mem_res_from_csr = 1'b0;
        mem_csr_num      = '0;
        mem_csr_we       = 1'b0;
        mem_csr_wmask    = '0;
        mem_csr_wvalue   = '0;
        mem_ertn         = 1'b0;
        mem_excp         = '0;
        mem_vaddr        = '0;
        hw_int           = '0;
        ipi_int          = 1'b0;
        rf_raddr         = '0;
        issued           = 0;
        model_reset();
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        // first instruction reads crmd into r1
        drive_instr(1'b1);
        @(negedge clk);
        check_outputs();
        while (issued < n_instr) begin
            run_cycle(1'b0);
        end
        repeat (3) run_cycle(1'b1);
        $display("test passed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the instruction stream did not finish within %0d cycles", max_cycles);
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== build.f ====
src/wb_pkg.sv
src/mem_wb_if.sv
src/wb_csr_if.sv
src/csr_file.sv
src/wb_stage.sv
src/reg_file.sv
src/wb_top.sv
+incdir+tb
tb/wb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module wb_tb -f build.f -o wb_sim
./obj_dir/wb_sim > sim.log 2>&1 || true
if grep -q "test failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
grep -q "test passed" sim.log
echo "simulation passed"
